//--- design/axi_wr_pkg.sv
package axi_wr_pkg;

    // bus geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int ADDR_ALIGN = 2;

    // burst and page limits
    localparam int MAX_BURST      = 16;
    localparam int BURST_W        = 4;
    localparam int BOUNDARY_BEATS = 1024;
    localparam int SECT_W         = $clog2(BOUNDARY_BEATS);
    localparam int PAGE_LSB       = SECT_W + ADDR_ALIGN;
    localparam int PAGE_W         = ADDR_W - PAGE_LSB;
    localparam int LOOP_W         = SECT_W - BURST_W;

    localparam int LEN_W       = 32;
    localparam int REQ_DEPTH   = 16;
    localparam int OUTSTANDING = 2;
    localparam int DATA_DEPTH  = OUTSTANDING * MAX_BURST;

    // fixed AW fields
    localparam logic [3:0] AWCACHE_VALUE = 4'b0011;
    localparam logic [2:0] AWPROT_VALUE  = 3'b000;
    localparam logic [1:0] AWBURST_INCR  = 2'b01;
    localparam logic [2:0] AWSIZE_VALUE  = 3'(ADDR_ALIGN);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
    } wr_req_t;

    // len in AXI encoding, beats minus one
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } aw_cmd_t;

    typedef struct packed {
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] data;
    } wbeat_t;

    typedef struct packed {
        logic last;
    } resp_tag_t;

    typedef logic [1:0] resp_t;

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic ACLK,
    input  logic ARESET,
    input  logic push,
    input  T     din,
    input  logic pop,
    output T     dout,
    output logic not_empty,
    output logic not_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign not_empty = (count != '0);
    assign not_full  = (count != CNT_W'(DEPTH));
    assign do_push   = push && not_full;
    assign do_pop    = pop && not_empty;

    // head word is visible without a read
    assign dout = mem[rd_ptr];

    always_ff @(posedge ACLK) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- design/burst_splitter.sv
`timescale 1ns/1ps

module burst_splitter (
    input  logic                  ACLK,
    input  logic                  ARESET,
    input  logic                  wreq_valid,
    input  axi_wr_pkg::wr_req_t   wreq,
    input  logic                  aw_ready,
    input  logic                  burst_room,
    input  logic                  tag_room,
    output logic                  wreq_ack,
    output logic                  aw_valid,
    output axi_wr_pkg::aw_cmd_t   aw_cmd,
    output logic                  burst_push,
    output logic                  tag_push,
    output axi_wr_pkg::resp_tag_t tag
);

    import axi_wr_pkg::*;

    wr_req_t             req_q;
    logic                req_avail;
    logic                next_req;
    logic                ready_for_req;
    logic [ADDR_W-1:0]   req_end;
    logic                req_busy;
    logic [ADDR_W-1:0]   start_addr;
    logic [ADDR_W-1:0]   end_addr;
    logic [PAGE_W-1:0]   sect_cnt;
    logic                first_sect;
    logic                last_sect;
    logic                next_sect;
    logic                ready_for_sect;
    logic [ADDR_W-1:0]   sect_addr;
    logic [SECT_W-1:0]   sect_len;
    logic [SECT_W-1:0]   start_to_4k;
    logic                sect_busy;
    logic [ADDR_W-1:0]   sect_addr_buf;
    logic [SECT_W-1:0]   sect_len_buf;
    logic                last_sect_buf;
    logic [LOOP_W-1:0]   loop_cnt;
    logic                last_loop;
    logic                next_loop;
    logic                ready_for_loop;
    logic [ADDR_W-1:0]   awaddr_next;
    logic [7:0]          awlen_next;

    sync_fifo #(
        .T     (wr_req_t),
        .DEPTH (REQ_DEPTH)
    ) u_req_fifo (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .push      (wreq_valid),
        .din       (wreq),
        .pop       (next_req),
        .dout      (req_q),
        .not_empty (req_avail),
        .not_full  (wreq_ack)
    );

    // address of the last byte of the request
    assign req_end       = req_q.addr + (req_q.len << ADDR_ALIGN) - 1;
    assign ready_for_req = !req_busy || (last_sect && next_sect);
    assign next_req      = req_avail && ready_for_req;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            req_busy <= 1'b0;
        end else if (next_req) begin
            req_busy <= 1'b1;
        end else if (last_sect && next_sect) begin
            req_busy <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (next_req) begin
            start_addr <= req_q.addr;
            end_addr   <= req_end;
        end
    end

    // page counter walks from the first to the last 4 KB page
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            sect_cnt <= '0;
        end else if (next_req) begin
            sect_cnt <= req_q.addr[ADDR_W-1:PAGE_LSB];
        end else if (next_sect) begin
            sect_cnt <= sect_cnt + 1'b1;
        end
    end

    assign first_sect  = (sect_cnt == start_addr[ADDR_W-1:PAGE_LSB]);
    assign last_sect   = (sect_cnt == end_addr[ADDR_W-1:PAGE_LSB]);
    assign next_sect   = req_busy && ready_for_sect;
    assign sect_addr   = first_sect ? start_addr : {sect_cnt, {PAGE_LSB{1'b0}}};
    assign start_to_4k = SECT_W'(BOUNDARY_BEATS - 1) - start_addr[PAGE_LSB-1:ADDR_ALIGN];

    // section length in beats minus one
    always_comb begin
        if (first_sect && last_sect) begin
            sect_len = end_addr[PAGE_LSB-1:ADDR_ALIGN] - start_addr[PAGE_LSB-1:ADDR_ALIGN];
        end else if (first_sect) begin
            sect_len = start_to_4k;
        end else if (last_sect) begin
            sect_len = end_addr[PAGE_LSB-1:ADDR_ALIGN];
        end else begin
            sect_len = SECT_W'(BOUNDARY_BEATS - 1);
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            sect_busy <= 1'b0;
        end else if (next_sect) begin
            sect_busy <= 1'b1;
        end else if (last_loop && next_loop) begin
            sect_busy <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (next_sect) begin
            sect_addr_buf <= sect_addr;
            sect_len_buf  <= sect_len;
            last_sect_buf <= last_sect;
        end
    end

    assign ready_for_sect = !sect_busy || (last_loop && next_loop);

    // a pending push has not reached the receivers' counts yet
    assign ready_for_loop = !(aw_valid && !aw_ready) && !burst_push && burst_room && tag_room;
    assign next_loop      = sect_busy && ready_for_loop;
    assign last_loop      = (loop_cnt == sect_len_buf[SECT_W-1:BURST_W]);

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            loop_cnt <= '0;
        end else if (next_sect) begin
            loop_cnt <= '0;
        end else if (next_loop) begin
            loop_cnt <= loop_cnt + 1'b1;
        end
    end

    assign awaddr_next = (loop_cnt == '0) ? sect_addr_buf :
                         aw_cmd.addr + ((ADDR_W'(aw_cmd.len) + 1) << ADDR_ALIGN);
    assign awlen_next  = last_loop ? 8'(sect_len_buf[BURST_W-1:0]) : 8'(MAX_BURST - 1);

    always_ff @(posedge ACLK) begin
        if (next_loop) begin
            aw_cmd.addr <= awaddr_next;
            aw_cmd.len  <= awlen_next;
            tag.last    <= last_loop && last_sect_buf;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_valid   <= 1'b0;
            burst_push <= 1'b0;
        end else begin
            burst_push <= next_loop;
            if (next_loop) begin
                aw_valid <= 1'b1;
            end else if (aw_ready) begin
                aw_valid <= 1'b0;
            end
        end
    end

    assign tag_push = burst_push;

endmodule

//--- design/wdata_beat_gen.sv
`timescale 1ns/1ps

module wdata_beat_gen (
    input  logic               ACLK,
    input  logic               ARESET,
    input  logic               wdata_valid,
    input  axi_wr_pkg::wbeat_t wdata,
    input  logic               burst_push,
    input  logic [7:0]         burst_len,
    input  logic               w_ready,
    output logic               wdata_ack,
    output logic               burst_room,
    output logic               w_valid,
    output axi_wr_pkg::wbeat_t w_beat,
    output logic               w_last
);

    import axi_wr_pkg::*;

    wbeat_t     data_q;
    logic       data_avail;
    logic [7:0] len_q;
    logic       len_avail;
    logic [7:0] beat_cnt;
    logic       ready_for_data;
    logic       next_data;
    logic       next_burst;

    sync_fifo #(
        .T     (wbeat_t),
        .DEPTH (DATA_DEPTH)
    ) u_data_fifo (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .push      (wdata_valid),
        .din       (wdata),
        .pop       (next_data),
        .dout      (data_q),
        .not_empty (data_avail),
        .not_full  (wdata_ack)
    );

    sync_fifo #(
        .T     (logic [7:0]),
        .DEPTH (REQ_DEPTH)
    ) u_len_fifo (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .push      (burst_push),
        .din       (burst_len),
        .pop       (next_burst),
        .dout      (len_q),
        .not_empty (len_avail),
        .not_full  (burst_room)
    );

    // output register free or draining this cycle
    assign ready_for_data = !(w_valid && !w_ready);
    assign next_data      = len_avail && data_avail && ready_for_data;
    assign next_burst     = next_data && (beat_cnt == len_q);

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            beat_cnt <= '0;
        end else if (next_burst) begin
            beat_cnt <= '0;
        end else if (next_data) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (next_data) begin
            w_beat <= data_q;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            w_valid <= 1'b0;
            w_last  <= 1'b0;
        end else if (next_data) begin
            w_valid <= 1'b1;
            w_last  <= next_burst;
        end else if (w_ready) begin
            w_valid <= 1'b0;
            w_last  <= 1'b0;
        end
    end

endmodule

//--- design/bresp_merger.sv
`timescale 1ns/1ps

module bresp_merger (
    input  logic                  ACLK,
    input  logic                  ARESET,
    input  logic                  tag_push,
    input  axi_wr_pkg::resp_tag_t tag,
    input  logic                  b_valid,
    input  axi_wr_pkg::resp_t     b_resp,
    input  logic                  wrsp_ack,
    output logic                  tag_room,
    output logic                  b_ready,
    output logic                  wrsp_valid,
    output axi_wr_pkg::resp_t     wrsp
);

    import axi_wr_pkg::*;

    resp_tag_t tag_q;
    logic      b_hs;
    logic      b_hs_q;
    logic      b_last_q;
    resp_t     b_resp_q;
    resp_t     hold;
    resp_t     merged;
    logic      rsp_push;
    logic      rsp_not_full;

    // one tag per burst still waiting for its B
    sync_fifo #(
        .T     (resp_tag_t),
        .DEPTH (OUTSTANDING)
    ) u_tag_fifo (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .push      (tag_push),
        .din       (tag),
        .pop       (b_hs),
        .dout      (tag_q),
        .not_empty (),
        .not_full  (tag_room)
    );

    sync_fifo #(
        .T     (resp_t),
        .DEPTH (REQ_DEPTH)
    ) u_rsp_fifo (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .push      (rsp_push),
        .din       (merged),
        .pop       (wrsp_ack),
        .dout      (wrsp),
        .not_empty (wrsp_valid),
        .not_full  (rsp_not_full)
    );

    // keep a slot for the push still in flight
    assign b_ready = rsp_not_full && !rsp_push;
    assign b_hs    = b_valid && b_ready;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            b_hs_q <= 1'b0;
        end else begin
            b_hs_q <= b_hs;
        end
    end

    always_ff @(posedge ACLK) begin
        if (b_hs) begin
            b_resp_q <= b_resp;
            b_last_q <= tag_q.last;
        end
    end

    // first error seen wins
    assign merged   = hold[1] ? hold : b_resp_q;
    assign rsp_push = b_hs_q && b_last_q;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            hold <= RESP_OKAY;
        end else if (b_hs_q) begin
            hold <= b_last_q ? RESP_OKAY : merged;
        end
    end

endmodule

//--- design/axi_write_master.sv
`timescale 1ns/1ps

module axi_write_master (
    input  logic                          ACLK,
    input  logic                          ARESET,
    // user side
    input  logic                          wreq_valid,
    output logic                          wreq_ack,
    input  axi_wr_pkg::wr_req_t           wreq,
    input  logic                          wdata_valid,
    output logic                          wdata_ack,
    input  axi_wr_pkg::wbeat_t            wdata,
    output logic                          wrsp_valid,
    input  logic                          wrsp_ack,
    output axi_wr_pkg::resp_t             wrsp,
    // AW channel
    output logic [axi_wr_pkg::ADDR_W-1:0] AWADDR,
    output logic [7:0]                    AWLEN,
    output logic [2:0]                    AWSIZE,
    output logic [1:0]                    AWBURST,
    output logic [3:0]                    AWCACHE,
    output logic [2:0]                    AWPROT,
    output logic                          AWVALID,
    input  logic                          AWREADY,
    // W channel
    output logic [axi_wr_pkg::DATA_W-1:0] WDATA,
    output logic [axi_wr_pkg::STRB_W-1:0] WSTRB,
    output logic                          WLAST,
    output logic                          WVALID,
    input  logic                          WREADY,
    // B channel
    input  axi_wr_pkg::resp_t             BRESP,
    input  logic                          BVALID,
    output logic                          BREADY
);

    import axi_wr_pkg::*;

    aw_cmd_t   aw_cmd;
    wbeat_t    w_beat;
    resp_tag_t tag;
    logic      burst_push;
    logic      tag_push;
    logic      burst_room;
    logic      tag_room;

    burst_splitter u_splitter (
        .ACLK       (ACLK),
        .ARESET     (ARESET),
        .wreq_valid (wreq_valid),
        .wreq       (wreq),
        .aw_ready   (AWREADY),
        .burst_room (burst_room),
        .tag_room   (tag_room),
        .wreq_ack   (wreq_ack),
        .aw_valid   (AWVALID),
        .aw_cmd     (aw_cmd),
        .burst_push (burst_push),
        .tag_push   (tag_push),
        .tag        (tag)
    );

    wdata_beat_gen u_wdata (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .wdata_valid (wdata_valid),
        .wdata       (wdata),
        .burst_push  (burst_push),
        .burst_len   (aw_cmd.len),
        .w_ready     (WREADY),
        .wdata_ack   (wdata_ack),
        .burst_room  (burst_room),
        .w_valid     (WVALID),
        .w_beat      (w_beat),
        .w_last      (WLAST)
    );

    bresp_merger u_bresp (
        .ACLK       (ACLK),
        .ARESET     (ARESET),
        .tag_push   (tag_push),
        .tag        (tag),
        .b_valid    (BVALID),
        .b_resp     (BRESP),
        .wrsp_ack   (wrsp_ack),
        .tag_room   (tag_room),
        .b_ready    (BREADY),
        .wrsp_valid (wrsp_valid),
        .wrsp       (wrsp)
    );

    assign AWADDR  = aw_cmd.addr;
    assign AWLEN   = aw_cmd.len;
    assign AWSIZE  = AWSIZE_VALUE;
    assign AWBURST = AWBURST_INCR;
    assign AWCACHE = AWCACHE_VALUE;
    assign AWPROT  = AWPROT_VALUE;
    assign WDATA   = w_beat.data;
    assign WSTRB   = w_beat.strb;

endmodule

//--- verification/axi_write_assert.sv
`timescale 1ns/1ps

module axi_write_assert (
    input logic        ACLK,
    input logic        ARESET,
    input logic        valid,
    input logic        ready,
    input logic [63:0] payload,
    input logic        check_aw,
    input logic [31:0] aw_addr,
    input logic [7:0]  aw_len
);

    int          fail_count = 0;
    logic [12:0] aw_end;

    // one past the last byte, relative to the page start
    assign aw_end = {1'b0, aw_addr[11:0]} + ((13'(aw_len) + 13'd1) << 2);

    property hold_until_ready;
        @(posedge ACLK) disable iff (ARESET)
        valid && !ready |=> valid && $stable(payload);
    endproperty

    a_hold: assert property (hold_until_ready) else begin
        fail_count++;
        $error("valid dropped or payload changed before ready");
    end

    a_len: assert property (@(posedge ACLK) disable iff (ARESET)
        check_aw && valid |-> aw_len <= 8'd15) else begin
        fail_count++;
        $error("AW burst longer than 16 beats");
    end

    a_page: assert property (@(posedge ACLK) disable iff (ARESET)
        check_aw && valid |-> aw_end <= 13'h1000) else begin
        fail_count++;
        $error("AW burst crosses a 4 KB boundary");
    end

endmodule

bind burst_splitter axi_write_assert u_aw_check (
    .ACLK     (ACLK),
    .ARESET   (ARESET),
    .valid    (aw_valid),
    .ready    (aw_ready),
    .payload  ({24'd0, aw_cmd}),
    .check_aw (1'b1),
    .aw_addr  (aw_cmd.addr),
    .aw_len   (aw_cmd.len)
);

bind wdata_beat_gen axi_write_assert u_w_check (
    .ACLK     (ACLK),
    .ARESET   (ARESET),
    .valid    (w_valid),
    .ready    (w_ready),
    .payload  ({27'd0, w_last, w_beat}),
    .check_aw (1'b0),
    .aw_addr  (32'd0),
    .aw_len   (8'd0)
);

//--- verification/tb_axi_write_master.sv
`timescale 1ns/1ps

module tb_axi_write_master;

    import axi_wr_pkg::*;

    localparam int         NUM_ROWS    = 8;
    localparam int         NO_ERR      = 255;
    localparam int         CYC_PER_BEAT = 200;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // err_burst is the burst index within the request that gets SLVERR
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] len;
        logic [7:0]  err_burst;
    } row_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic        err;
        logic [7:0]  row;
    } burst_t;

    logic        ACLK;
    logic        ARESET;
    logic        wreq_valid;
    logic        wreq_ack;
    wr_req_t     wreq;
    logic        wdata_valid;
    logic        wdata_ack;
    wbeat_t      wdata;
    logic        wrsp_valid;
    logic        wrsp_ack;
    resp_t       wrsp;
    logic [31:0] AWADDR;
    logic [7:0]  AWLEN;
    logic [2:0]  AWSIZE;
    logic [1:0]  AWBURST;
    logic [3:0]  AWCACHE;
    logic [2:0]  AWPROT;
    logic        AWVALID;
    logic        AWREADY;
    logic [31:0] WDATA;
    logic [3:0]  WSTRB;
    logic        WLAST;
    logic        WVALID;
    logic        WREADY;
    resp_t       BRESP;
    logic        BVALID;
    logic        BREADY;

    row_t        rows [NUM_ROWS];
    resp_t       exp_rsp [NUM_ROWS];
    logic        row_bad [NUM_ROWS];
    burst_t      exp_bursts [$];
    integer      seed;
    logic [31:0] rnd;
    int          errors;
    int          checks;
    int          total_beats;
    int          aw_idx;
    int          w_idx;
    int          w_beat_cnt;
    int          w_word;
    int          b_idx;
    int          rsp_idx;
    int          word;

    axi_write_master uut (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .wreq_valid  (wreq_valid),
        .wreq_ack    (wreq_ack),
        .wreq        (wreq),
        .wdata_valid (wdata_valid),
        .wdata_ack   (wdata_ack),
        .wdata       (wdata),
        .wrsp_valid  (wrsp_valid),
        .wrsp_ack    (wrsp_ack),
        .wrsp        (wrsp),
        .AWADDR      (AWADDR),
        .AWLEN       (AWLEN),
        .AWSIZE      (AWSIZE),
        .AWBURST     (AWBURST),
        .AWCACHE     (AWCACHE),
        .AWPROT      (AWPROT),
        .AWVALID     (AWVALID),
        .AWREADY     (AWREADY),
        .WDATA       (WDATA),
        .WSTRB       (WSTRB),
        .WLAST       (WLAST),
        .WVALID      (WVALID),
        .WREADY      (WREADY),
        .BRESP       (BRESP),
        .BVALID      (BVALID),
        .BREADY      (BREADY)
    );

    initial begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, input int row);
        errors++;
        row_bad[row] = 1'b1;
        $display("Mismatch at %0t: %s got %h expected %h (row %0d)", $time, name, got, exp, row);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic set_row(input int i, input logic [31:0] addr, input logic [31:0] len,
                           input int err_burst);
        rows[i].addr      = addr;
        rows[i].len       = len;
        rows[i].err_burst = 8'(err_burst);
    endtask

    // next burst takes the fewest of remaining beats, 16 and beats left in the 4 KB page
    task automatic build_expected();
        logic [31:0] addr;
        int          rem;
        int          to_page;
        int          n;
        int          k;
        burst_t      b;
        for (int r = 0; r < NUM_ROWS; r++) begin
            addr        = rows[r].addr;
            rem         = int'(rows[r].len);
            k           = 0;
            exp_rsp[r]  = RESP_OKAY;
            row_bad[r]  = 1'b0;
            total_beats += rem;
            while (rem > 0) begin
                to_page = (4096 - int'(addr[11:0])) / 4;
                n = (rem < 16) ? rem : 16;
                if (to_page < n) begin
                    n = to_page;
                end
                b.addr = addr;
                b.len  = 8'(n - 1);
                b.err  = (k == int'(rows[r].err_burst));
                b.row  = 8'(r);
                if (b.err) begin
                    exp_rsp[r] = RESP_SLVERR;
                end
                exp_bursts.push_back(b);
                addr = addr + 32'(n * 4);
                rem  = rem - n;
                k++;
            end
        end
    endtask

    // called on a falling edge; ack does not depend on valid
    task automatic push_request(input row_t row);
        wreq_valid = 1'b1;
        wreq.addr  = row.addr;
        wreq.len   = row.len;
        while (!wreq_ack) @(negedge ACLK);
        @(negedge ACLK);
        wreq_valid = 1'b0;
    endtask

    task automatic push_word(input logic [31:0] data);
        wdata_valid = 1'b1;
        wdata.data  = data;
        wdata.strb  = '1;
        while (!wdata_ack) @(negedge ACLK);
        @(negedge ACLK);
        wdata_valid = 1'b0;
    endtask

    task automatic check_aw();
        burst_t b;
        assert (aw_idx < exp_bursts.size()) else report_failure("AW burst beyond the expected list");
        if (aw_idx < exp_bursts.size()) begin
            b = exp_bursts[aw_idx];
            checks += 6;
            assert (AWADDR == b.addr) else report_mismatch("AWADDR", AWADDR, b.addr, b.row);
            assert (AWLEN == b.len) else report_mismatch("AWLEN", AWLEN, b.len, b.row);
            assert (AWSIZE == 3'd2) else report_mismatch("AWSIZE", AWSIZE, 3'd2, b.row);
            assert (AWBURST == 2'b01) else report_mismatch("AWBURST", AWBURST, 2'b01, b.row);
            assert (AWCACHE == AWCACHE_VALUE)
                else report_mismatch("AWCACHE", AWCACHE, AWCACHE_VALUE, b.row);
            assert (AWPROT == AWPROT_VALUE)
                else report_mismatch("AWPROT", AWPROT, AWPROT_VALUE, b.row);
        end
        aw_idx++;
    endtask

    task automatic check_w();
        burst_t b;
        logic   exp_last;
        assert (w_idx < exp_bursts.size()) else report_failure("W beat after the last expected burst");
        if (w_idx < exp_bursts.size()) begin
            b        = exp_bursts[w_idx];
            exp_last = (w_beat_cnt == int'(b.len));
            checks += 3;
            assert (WDATA == 32'(w_word)) else report_mismatch("WDATA", WDATA, 32'(w_word), b.row);
            assert (WSTRB == 4'hf) else report_mismatch("WSTRB", WSTRB, 4'hf, b.row);
            assert (WLAST == exp_last) else report_mismatch("WLAST", WLAST, exp_last, b.row);
            w_word++;
            if (exp_last) begin
                w_beat_cnt = 0;
                w_idx++;
            end else begin
                w_beat_cnt++;
            end
        end
    endtask

    task automatic check_rsp();
        assert (rsp_idx < NUM_ROWS) else report_failure("response with no request outstanding");
        if (rsp_idx < NUM_ROWS) begin
            checks++;
            assert (wrsp == exp_rsp[rsp_idx])
                else report_mismatch("wrsp", wrsp, exp_rsp[rsp_idx], rsp_idx);
            $display("row %0d addr %h len %0d resp %0d: %s", rsp_idx, rows[rsp_idx].addr,
                     rows[rsp_idx].len, wrsp, row_bad[rsp_idx] ? "error" : "ok");
        end
        rsp_idx++;
    endtask

    // slave model and response monitor sampling every handshake on the falling edge
    always @(negedge ACLK) begin
        if (ARESET !== 1'b0) begin
            AWREADY  = 1'b0;
            WREADY   = 1'b0;
            BVALID   = 1'b0;
            wrsp_ack = 1'b0;
        end else begin
            rnd = $random(seed);
            // B only for bursts whose AW and WLAST are done
            if (b_idx < aw_idx && b_idx < w_idx) begin
                BVALID = 1'b1;
                BRESP  = exp_bursts[b_idx].err ? RESP_SLVERR : RESP_OKAY;
                if (BREADY) begin
                    b_idx++;
                end
            end else begin
                BVALID = 1'b0;
            end
            AWREADY = rnd[0];
            if (AWVALID && AWREADY) begin
                check_aw();
            end
            WREADY = rnd[1];
            if (WVALID && WREADY) begin
                check_w();
            end
            wrsp_ack = rnd[2];
            if (wrsp_valid && wrsp_ack) begin
                check_rsp();
            end
        end
    end

    initial begin
        @(negedge ARESET);
        repeat (total_beats * CYC_PER_BEAT) @(posedge ACLK);
        $display("timeout: only %0d of %0d responses arrived", rsp_idx, NUM_ROWS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        ARESET      = 1'b1;
        wreq_valid  = 1'b0;
        wreq        = '0;
        wdata_valid = 1'b0;
        wdata       = '0;
        wrsp_ack    = 1'b0;
        AWREADY     = 1'b0;
        WREADY      = 1'b0;
        BVALID      = 1'b0;
        BRESP       = RESP_OKAY;
        seed        = 32'he1a44ff9;
        errors      = 0;
        checks      = 0;
        total_beats = 0;
        aw_idx      = 0;
        w_idx       = 0;
        w_beat_cnt  = 0;
        w_word      = 0;
        b_idx       = 0;
        rsp_idx     = 0;
        word        = 0;
        set_row(0, 32'h0000_0100, 4, NO_ERR);
        set_row(1, 32'h0000_0ff0, 8, NO_ERR);
        set_row(2, 32'h0000_2000, 40, 1);
        set_row(3, 32'h0000_3fc0, 50, 3);
        set_row(4, 32'h0001_0004, 1, NO_ERR);
        set_row(5, 32'h0002_0f80, 100, 0);
        set_row(6, 32'h0003_0010, 17, NO_ERR);
        set_row(7, 32'h0004_1ffc, 3, 1);
        build_expected();
        repeat (16) @(posedge ACLK);
        @(negedge ACLK);
        ARESET <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            push_request(rows[r]);
            for (int j = 0; j < int'(rows[r].len); j++) begin
                push_word(32'(word));
                word++;
            end
        end
        wait (rsp_idx == NUM_ROWS);
        // idle a while so stray beats or responses still show up
        repeat (40) @(negedge ACLK);
        assert (aw_idx == exp_bursts.size()) else report_failure("wrong number of AW bursts");
        assert (w_idx == exp_bursts.size()) else report_failure("wrong number of W bursts");
        assert (b_idx == exp_bursts.size()) else report_failure("wrong number of B responses");
        assert (rsp_idx == NUM_ROWS) else report_failure("extra user responses");
        errors += uut.u_splitter.u_aw_check.fail_count + uut.u_wdata.u_w_check.fail_count;
        $display("%0d rows, %0d bursts, %0d checks, %0d errors",
                 NUM_ROWS, exp_bursts.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
design/axi_wr_pkg.sv
design/sync_fifo.sv
design/burst_splitter.sv
design/wdata_beat_gen.sv
design/bresp_merger.sv
design/axi_write_master.sv
verification/axi_write_assert.sv
verification/tb_axi_write_master.sv
